//--- files.f
hdl/cpu_pkg.sv
hdl/instr_queue.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/forward_unit.sv
hdl/execute_stage.sv
hdl/retire_stage.sv
hdl/pipeline.sv
testbench/tb_clock_gen.sv
testbench/pipeline_assert.sv
testbench/tb_pipeline.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_pipeline -f files.f -o sim_pipeline
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_pipeline > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- testbench/tb_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pipeline;

import cpu_pkg::*;

localparam int NUM_INSTR  = 500;
localparam int WAIT_LIMIT = 100;

// Instruction kinds 0 to 13 are R-type, 14 to 20 are I-type
localparam funct_t R_FUNCTS [14] = '{
    FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU,
    FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV
};
localparam opcode_t I_OPS [7] = '{
    OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI
};

logic      clk;
logic      rst_n;
logic      instr_valid;
instr_t    instr;
logic      credit;
logic      retire_valid;
reg_addr_t retire_addr;
word_t     retire_data;

logic [31:0] rng_state;
word_t       model_regs [32];
reg_addr_t   exp_addr_q [$];
word_t       exp_data_q [$];
int          sent;
int          retired;
int          returned;
int          addr_errors;
int          data_errors;
int          flow_errors;
logic        timed_out;

tb_clock_gen u_clk_gen (
    .clk   ( clk   ),
    .rst_n ( rst_n )
);

pipeline u_dut (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .instr_valid  ( instr_valid  ),
    .instr        ( instr        ),
    .credit       ( credit       ),
    .retire_valid ( retire_valid ),
    .retire_addr  ( retire_addr  ),
    .retire_data  ( retire_data  )
);

//////////////////////////////////////////////////////////////////////
//  Helpers
//////////////////////////////////////////////////////////////////////

// xorshift32
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

task automatic check_addr(reg_addr_t got, reg_addr_t expected);
    if (got !== expected) begin
        addr_errors++;
        $display("Mismatch at %0t: retire_addr is %0d, expected %0d", $time, got, expected);
    end
endtask

task automatic check_data(word_t got, word_t expected);
    if (got !== expected) begin
        data_errors++;
        $display("Mismatch at %0t: retire_data is %h, expected %h", $time, got, expected);
    end
endtask

task automatic report_timeout(string what);
    timed_out = 1'b1;
    flow_errors++;
    $display("Timeout at %0t: %s", $time, what);
endtask

// Outputs are read mid-cycle, away from the rising edge
task automatic sample_outputs();
    if (rst_n) begin
        if ((sent == 0) && (credit || retire_valid)) begin
            flow_errors++;
            $display("Output went active at %0t before any instruction was sent", $time);
        end
        if (credit) begin
            returned++;
        end
        if (returned > sent) begin
            flow_errors++;
            $display("More credits came back than instructions were sent at %0t", $time);
        end
        if (retire_valid) begin
            retired++;
            if (exp_addr_q.size() == 0) begin
                flow_errors++;
                $display("An instruction retired at %0t with none outstanding", $time);
            end else begin
                check_addr(retire_addr, exp_addr_q.pop_front());
                check_data(retire_data, exp_data_q.pop_front());
            end
        end
    end
endtask

task automatic step();
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
endtask

//////////////////////////////////////////////////////////////////////
//  Stimulus and reference model
//////////////////////////////////////////////////////////////////////

task automatic send_random();
    logic [31:0] r;
    int          kind;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    shamt_t      sa;
    imm_t        imm;
    word_t       a;
    word_t       b;
    word_t       sext;
    word_t       zext;
    word_t       res;
    reg_addr_t   dest;
    instr_t      instr_word;

    r    = next_rand();
    kind = int'(next_rand() % 32'd21);
    // Registers 0 to 7 only, so dependencies are dense
    rs   = {2'b00, r[2:0]};
    rt   = {2'b00, r[5:3]};
    rd   = {2'b00, r[8:6]};
    sa   = r[13:9];
    imm  = r[31:16];
    a    = model_regs[rs];
    b    = model_regs[rt];
    sext = {{16{imm[15]}}, imm};
    zext = {16'd0, imm};

    if (kind < 14) begin
        instr_word = {OP_RTYPE, rs, rt, rd, sa, R_FUNCTS[kind]};
        dest       = rd;
        case (R_FUNCTS[kind])
            FN_ADDU: res = a + b;
            FN_SUBU: res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_XOR:  res = a ^ b;
            FN_NOR:  res = ~(a | b);
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
            FN_SLL:  res = b << sa;
            FN_SRL:  res = b >> sa;
            FN_SRA:  res = word_t'($signed(b) >>> sa);
            FN_SLLV: res = b << a[4:0];
            FN_SRLV: res = b >> a[4:0];
            default: res = word_t'($signed(b) >>> a[4:0]);
        endcase
    end else begin
        instr_word = {I_OPS[kind - 14], rs, rt, imm};
        dest       = rt;
        case (I_OPS[kind - 14])
            OP_ADDIU: res = a + sext;
            OP_SLTI:  res = ($signed(a) < $signed(sext)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < sext) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & zext;
            OP_ORI:   res = a | zext;
            OP_XORI:  res = a ^ zext;
            default:  res = {imm, 16'd0};
        endcase
    end

    exp_addr_q.push_back(dest);
    exp_data_q.push_back(res);
    // $0 keeps zero, the retire port still shows the result
    if (dest != '0) begin
        model_regs[dest] = res;
    end
    instr_valid <= 1'b1;
    instr       <= instr_word;
    sent++;
endtask

initial begin
    int wait_cycles;
    int stall;

    rng_state   = 32'd27617;
    sent        = 0;
    retired     = 0;
    returned    = 0;
    addr_errors = 0;
    data_errors = 0;
    flow_errors = 0;
    timed_out   = 1'b0;
    for (int i = 0; i < 32; i++) begin
        model_regs[i] = '0;
    end
    instr_valid <= 1'b0;
    instr       <= '0;

    wait_cycles = 0;
    while ((rst_n !== 1'b1) && !timed_out) begin
        step();
        wait_cycles++;
        if (wait_cycles > WAIT_LIMIT) begin
            report_timeout("reset was never released");
        end
    end

    // A few idle cycles, outputs must stay low
    repeat (3) step();

    // Credits held = QUEUE_DEPTH - sent + returned
    stall = 0;
    while ((sent < NUM_INSTR) && !timed_out) begin
        if ((QUEUE_DEPTH - sent + returned > 0) && ((next_rand() % 32'd5) != 32'd0)) begin
            send_random();
            stall = 0;
        end else begin
            instr_valid <= 1'b0;
            if (QUEUE_DEPTH - sent + returned == 0) begin
                stall++;
            end
            if (stall > WAIT_LIMIT) begin
                report_timeout("no credit came back to the sender");
            end
        end
        step();
    end
    instr_valid <= 1'b0;

    wait_cycles = 0;
    while (((retired < sent) || (returned < sent)) && !timed_out) begin
        step();
        wait_cycles++;
        if (wait_cycles > WAIT_LIMIT) begin
            report_timeout("the pipeline did not drain");
        end
    end

    // Watch for stray retirements after the drain
    repeat (4) step();
    if (!timed_out && ((retired != sent) || (returned != sent) || (exp_addr_q.size() != 0))) begin
        flow_errors++;
        $display("Count mismatch after drain: sent %0d, retired %0d, credits %0d",
                 sent, retired, returned);
    end

    $display("Errors: addr %0d, data %0d, flow %0d; sent %0d, retired %0d, credits %0d",
             addr_errors, data_errors, flow_errors, sent, retired, returned);
    if ((addr_errors + data_errors + flow_errors) == 0) begin
        $display("Verification passed");
    end else begin
        $display("Verification failed");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- testbench/pipeline_assert.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         instr_valid,
    input logic                         credit,
    input logic [cpu_pkg::CREDIT_W-1:0] count,
    input logic                         if_valid,
    input cpu_pkg::instr_t              if_instr
);

import cpu_pkg::*;

logic [CREDIT_W-1:0] occupancy;

// Entries held, seen only through pushes and credit pulses
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        occupancy <= '0;
    end else begin
        occupancy <= occupancy + CREDIT_W'(instr_valid) - CREDIT_W'(credit);
    end
end

// A sender with no credit left must stay quiet
a_no_send_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    (count == CREDIT_W'(QUEUE_DEPTH)) |-> !instr_valid
) else $error("instr_valid raised while the instruction queue is full");

// Credit only accompanies a pop
a_no_credit_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    credit |-> (occupancy != '0)
) else $error("credit pulsed while the instruction queue is empty");

a_known_if_instr: assert property (
    @(posedge clk) disable iff (!rst_n)
    if_valid |-> !$isunknown(if_instr)
) else $error("if_instr carries unknown bits while if_valid is high");

endmodule

bind instr_queue pipeline_assert u_queue_assert (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .instr_valid ( instr_valid ),
    .credit      ( credit      ),
    .count       ( count       ),
    .if_valid    ( if_valid    ),
    .if_instr    ( if_instr    )
);

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

// 100 ns period
initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// Reset held over the first two rising edges
initial begin
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
end

endmodule

`default_nettype wire

//--- hdl/pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module pipeline (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               instr_valid,
    input  cpu_pkg::instr_t    instr,
    output logic               credit,
    output logic               retire_valid,
    output cpu_pkg::reg_addr_t retire_addr,
    output cpu_pkg::word_t     retire_data
);

import cpu_pkg::*;

//////////////////////////////////////////////////////////////////////
//  Stage signals
//////////////////////////////////////////////////////////////////////

logic      if_valid;
instr_t    if_instr;

reg_addr_t rs_addr;
reg_addr_t rt_addr;
word_t     rs_data;
word_t     rt_data;

logic      ex_valid;
logic      ex_reg_w;
alu_op_t   ex_alu_op;
shift_op_t ex_shift_op;
res_sel_t  ex_res_sel;
logic      ex_b_imm;
logic      ex_shamt_var;
shamt_t    ex_shamt;
word_t     ex_imm;
word_t     ex_op_a;
word_t     ex_op_b;
reg_addr_t ex_rs_addr;
reg_addr_t ex_rt_addr;
reg_addr_t ex_rd_addr;

fwd_sel_t  fwd_a;
fwd_sel_t  fwd_b;

logic      mem_valid;
logic      mem_reg_w;
reg_addr_t mem_rd_addr;
word_t     mem_result;

logic      wb_valid;
logic      wb_reg_w;
reg_addr_t wb_rd_addr;
word_t     wb_data;

//////////////////////////////////////////////////////////////////////
//  IF and ID
//////////////////////////////////////////////////////////////////////

instr_queue u_queue (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .instr_valid ( instr_valid ),
    .instr       ( instr       ),
    .if_valid    ( if_valid    ),
    .if_instr    ( if_instr    ),
    .credit      ( credit      )
);

decode_stage u_decode (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .if_valid     ( if_valid     ),
    .if_instr     ( if_instr     ),
    .rs_data      ( rs_data      ),
    .rt_data      ( rt_data      ),
    .rs_addr      ( rs_addr      ),
    .rt_addr      ( rt_addr      ),
    .ex_valid     ( ex_valid     ),
    .ex_reg_w     ( ex_reg_w     ),
    .ex_alu_op    ( ex_alu_op    ),
    .ex_shift_op  ( ex_shift_op  ),
    .ex_res_sel   ( ex_res_sel   ),
    .ex_b_imm     ( ex_b_imm     ),
    .ex_shamt_var ( ex_shamt_var ),
    .ex_shamt     ( ex_shamt     ),
    .ex_imm       ( ex_imm       ),
    .ex_op_a      ( ex_op_a      ),
    .ex_op_b      ( ex_op_b      ),
    .ex_rs_addr   ( ex_rs_addr   ),
    .ex_rt_addr   ( ex_rt_addr   ),
    .ex_rd_addr   ( ex_rd_addr   )
);

// Written from WB, read from ID in the same cycle
reg_file u_gpr (
    .clk     ( clk        ),
    .rst_n   ( rst_n      ),
    .rs_addr ( rs_addr    ),
    .rt_addr ( rt_addr    ),
    .rs_data ( rs_data    ),
    .rt_data ( rt_data    ),
    .wr_en   ( wb_reg_w   ),
    .wr_addr ( wb_rd_addr ),
    .wr_data ( wb_data    )
);

//////////////////////////////////////////////////////////////////////
//  EX, MEM and WB
//////////////////////////////////////////////////////////////////////

forward_unit u_fwd (
    .ex_rs_addr  ( ex_rs_addr  ),
    .ex_rt_addr  ( ex_rt_addr  ),
    .mem_rd_addr ( mem_rd_addr ),
    .wb_rd_addr  ( wb_rd_addr  ),
    .mem_reg_w   ( mem_reg_w   ),
    .wb_reg_w    ( wb_reg_w    ),
    .fwd_a       ( fwd_a       ),
    .fwd_b       ( fwd_b       )
);

execute_stage u_execute (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .ex_valid     ( ex_valid     ),
    .ex_reg_w     ( ex_reg_w     ),
    .ex_alu_op    ( ex_alu_op    ),
    .ex_shift_op  ( ex_shift_op  ),
    .ex_res_sel   ( ex_res_sel   ),
    .ex_b_imm     ( ex_b_imm     ),
    .ex_shamt_var ( ex_shamt_var ),
    .ex_shamt     ( ex_shamt     ),
    .ex_imm       ( ex_imm       ),
    .ex_op_a      ( ex_op_a      ),
    .ex_op_b      ( ex_op_b      ),
    .ex_rd_addr   ( ex_rd_addr   ),
    .fwd_a        ( fwd_a        ),
    .fwd_b        ( fwd_b        ),
    .wb_data      ( wb_data      ),
    .mem_valid    ( mem_valid    ),
    .mem_reg_w    ( mem_reg_w    ),
    .mem_rd_addr  ( mem_rd_addr  ),
    .mem_result   ( mem_result   )
);

retire_stage u_retire (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .mem_valid   ( mem_valid   ),
    .mem_reg_w   ( mem_reg_w   ),
    .mem_rd_addr ( mem_rd_addr ),
    .mem_result  ( mem_result  ),
    .wb_valid    ( wb_valid    ),
    .wb_reg_w    ( wb_reg_w    ),
    .wb_rd_addr  ( wb_rd_addr  ),
    .wb_data     ( wb_data     )
);

assign retire_valid = wb_valid;
assign retire_addr  = wb_rd_addr;
assign retire_data  = wb_data;

endmodule

`default_nettype wire

//--- hdl/retire_stage.sv
`timescale 1ns/10ps
`default_nettype none

module retire_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_valid,
    input  logic               mem_reg_w,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  cpu_pkg::word_t     mem_result,
    output logic               wb_valid,
    output logic               wb_reg_w,
    output cpu_pkg::reg_addr_t wb_rd_addr,
    output cpu_pkg::word_t     wb_data
);

import cpu_pkg::*;

// No memory access, so MEM only delays the result one cycle
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wb_valid   <= 1'b0;
        wb_reg_w   <= 1'b0;
        wb_rd_addr <= '0;
    end else begin
        wb_valid   <= mem_valid;
        wb_reg_w   <= mem_reg_w;
        wb_rd_addr <= mem_rd_addr;
    end
end

always_ff @(posedge clk) begin
    wb_data <= mem_result;
end

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               ex_valid,
    input  logic               ex_reg_w,
    input  cpu_pkg::alu_op_t   ex_alu_op,
    input  cpu_pkg::shift_op_t ex_shift_op,
    input  cpu_pkg::res_sel_t  ex_res_sel,
    input  logic               ex_b_imm,
    input  logic               ex_shamt_var,
    input  cpu_pkg::shamt_t    ex_shamt,
    input  cpu_pkg::word_t     ex_imm,
    input  cpu_pkg::word_t     ex_op_a,
    input  cpu_pkg::word_t     ex_op_b,
    input  cpu_pkg::reg_addr_t ex_rd_addr,
    input  cpu_pkg::fwd_sel_t  fwd_a,
    input  cpu_pkg::fwd_sel_t  fwd_b,
    input  cpu_pkg::word_t     wb_data,
    output logic               mem_valid,
    output logic               mem_reg_w,
    output cpu_pkg::reg_addr_t mem_rd_addr,
    output cpu_pkg::word_t     mem_result
);

import cpu_pkg::*;

word_t  a_fwd;
word_t  b_fwd;
word_t  op_b;
shamt_t shamt_sel;
word_t  alu_out;
word_t  shift_out;
word_t  result;

function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val);
    case (sel)
        FWD_MEM: return mem_result;
        FWD_WB:  return wb_data;
        default: return reg_val;
    endcase
endfunction

always_comb begin
    a_fwd = fwd_mux(fwd_a, ex_op_a);
    b_fwd = fwd_mux(fwd_b, ex_op_b);
end

assign op_b      = ex_b_imm ? ex_imm : b_fwd;
// Variable shifts take the low five bits of rs
assign shamt_sel = ex_shamt_var ? a_fwd[4:0] : ex_shamt;

always_comb begin
    case (ex_alu_op)
        ALU_SUB:  alu_out = a_fwd - op_b;
        ALU_AND:  alu_out = a_fwd & op_b;
        ALU_OR:   alu_out = a_fwd | op_b;
        ALU_XOR:  alu_out = a_fwd ^ op_b;
        ALU_NOR:  alu_out = ~(a_fwd | op_b);
        ALU_SLT:  alu_out = {31'd0, $signed(a_fwd) < $signed(op_b)};
        ALU_SLTU: alu_out = {31'd0, a_fwd < op_b};
        default:  alu_out = a_fwd + op_b;
    endcase
end

// Barrel shifter on rt
always_comb begin
    case (ex_shift_op)
        SH_RL:   shift_out = b_fwd >> shamt_sel;
        SH_RA:   shift_out = word_t'($signed(b_fwd) >>> shamt_sel);
        default: shift_out = b_fwd << shamt_sel;
    endcase
end

assign result = (ex_res_sel == RES_SHIFT) ? shift_out : alu_out;

// EX/MEM register
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        mem_valid   <= 1'b0;
        mem_reg_w   <= 1'b0;
        mem_rd_addr <= '0;
    end else begin
        mem_valid   <= ex_valid;
        mem_reg_w   <= ex_reg_w;
        mem_rd_addr <= ex_rd_addr;
    end
end

always_ff @(posedge clk) begin
    mem_result <= result;
end

endmodule

`default_nettype wire

//--- hdl/forward_unit.sv
`timescale 1ns/10ps
`default_nettype none

module forward_unit (
    input  cpu_pkg::reg_addr_t ex_rs_addr,
    input  cpu_pkg::reg_addr_t ex_rt_addr,
    input  cpu_pkg::reg_addr_t mem_rd_addr,
    input  cpu_pkg::reg_addr_t wb_rd_addr,
    input  logic               mem_reg_w,
    input  logic               wb_reg_w,
    output cpu_pkg::fwd_sel_t  fwd_a,
    output cpu_pkg::fwd_sel_t  fwd_b
);

import cpu_pkg::*;

// Younger result in MEM wins over WB
function automatic fwd_sel_t pick(reg_addr_t src, logic m_w, reg_addr_t m_rd,
                                  logic w_w, reg_addr_t w_rd);
    if (src == '0) begin
        return FWD_REG;
    end
    if (m_w && (m_rd == src)) begin
        return FWD_MEM;
    end
    if (w_w && (w_rd == src)) begin
        return FWD_WB;
    end
    return FWD_REG;
endfunction

assign fwd_a = pick(ex_rs_addr, mem_reg_w, mem_rd_addr, wb_reg_w, wb_rd_addr);
assign fwd_b = pick(ex_rt_addr, mem_reg_w, mem_rd_addr, wb_reg_w, wb_rd_addr);

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    input  logic               wr_en,
    input  cpu_pkg::reg_addr_t wr_addr,
    input  cpu_pkg::word_t     wr_data
);

import cpu_pkg::*;

// $0 has no storage
word_t regs [1:31];

// Same-cycle write from WB is visible to the reader
function automatic word_t read_port(reg_addr_t addr);
    if (addr == '0) begin
        return '0;
    end
    if (wr_en && (wr_addr == addr)) begin
        return wr_data;
    end
    return regs[addr];
endfunction

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
        end
    end else if (wr_en && (wr_addr != '0)) begin
        regs[wr_addr] <= wr_data;
    end
end

always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
end

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                if_valid,
    input  cpu_pkg::instr_t     if_instr,
    input  cpu_pkg::word_t      rs_data,
    input  cpu_pkg::word_t      rt_data,
    output cpu_pkg::reg_addr_t  rs_addr,
    output cpu_pkg::reg_addr_t  rt_addr,
    output logic                ex_valid,
    output logic                ex_reg_w,
    output cpu_pkg::alu_op_t    ex_alu_op,
    output cpu_pkg::shift_op_t  ex_shift_op,
    output cpu_pkg::res_sel_t   ex_res_sel,
    output logic                ex_b_imm,
    output logic                ex_shamt_var,
    output cpu_pkg::shamt_t     ex_shamt,
    output cpu_pkg::word_t      ex_imm,
    output cpu_pkg::word_t      ex_op_a,
    output cpu_pkg::word_t      ex_op_b,
    output cpu_pkg::reg_addr_t  ex_rs_addr,
    output cpu_pkg::reg_addr_t  ex_rt_addr,
    output cpu_pkg::reg_addr_t  ex_rd_addr
);

import cpu_pkg::*;

opcode_t   opcode;
reg_addr_t rs;
reg_addr_t rt;
reg_addr_t rd;
shamt_t    shamt;
funct_t    funct;
imm_t      imm;

logic      dec_ok;
logic      use_rs;
logic      use_rt;
logic      b_imm;
logic      shamt_var;
alu_op_t   alu_op;
shift_op_t shift_op;
res_sel_t  res_sel;
imm_ext_t  imm_ext;
word_t     imm_word;
reg_addr_t dest;

assign opcode = if_instr[31:26];
assign rs     = if_instr[25:21];
assign rt     = if_instr[20:16];
assign rd     = if_instr[15:11];
assign shamt  = if_instr[10:6];
assign funct  = if_instr[5:0];
assign imm    = if_instr[15:0];

//////////////////////////////////////////////////////////////////////
//  Decoder
//////////////////////////////////////////////////////////////////////

always_comb begin
    dec_ok    = 1'b1;
    use_rs    = 1'b1;
    use_rt    = 1'b0;
    b_imm     = 1'b1;
    shamt_var = 1'b0;
    alu_op    = ALU_ADD;
    shift_op  = SH_LL;
    res_sel   = RES_ALU;
    imm_ext   = EXT_SIGN;
    case (opcode)
        OP_RTYPE: begin
            use_rt = 1'b1;
            b_imm  = 1'b0;
            case (funct)
                FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
                    res_sel   = RES_SHIFT;
                    shamt_var = funct[2];
                    // Fixed shifts ignore rs
                    use_rs    = funct[2];
                    if (!funct[1]) begin
                        shift_op = SH_LL;
                    end else if (funct[0]) begin
                        shift_op = SH_RA;
                    end else begin
                        shift_op = SH_RL;
                    end
                end
                FN_ADDU: alu_op = ALU_ADD;
                FN_SUBU: alu_op = ALU_SUB;
                FN_AND:  alu_op = ALU_AND;
                FN_OR:   alu_op = ALU_OR;
                FN_XOR:  alu_op = ALU_XOR;
                FN_NOR:  alu_op = ALU_NOR;
                FN_SLT:  alu_op = ALU_SLT;
                FN_SLTU: alu_op = ALU_SLTU;
                default: dec_ok = 1'b0;
            endcase
        end
        OP_ADDIU: alu_op = ALU_ADD;
        OP_SLTI:  alu_op = ALU_SLT;
        OP_SLTIU: alu_op = ALU_SLTU;
        OP_ANDI: begin
            alu_op  = ALU_AND;
            imm_ext = EXT_ZERO;
        end
        OP_ORI: begin
            alu_op  = ALU_OR;
            imm_ext = EXT_ZERO;
        end
        OP_XORI: begin
            alu_op  = ALU_XOR;
            imm_ext = EXT_ZERO;
        end
        OP_LUI: begin
            // 0 | (imm << 16)
            alu_op  = ALU_OR;
            imm_ext = EXT_UPPER;
            use_rs  = 1'b0;
        end
        default: dec_ok = 1'b0;
    endcase

    // Undefined: both operands read $0, so the sum is zero
    if (!dec_ok) begin
        use_rs = 1'b0;
        use_rt = 1'b0;
        b_imm  = 1'b0;
    end
end

always_comb begin
    case (imm_ext)
        EXT_ZERO:  imm_word = {16'd0, imm};
        EXT_UPPER: imm_word = {imm, 16'd0};
        default:   imm_word = {{16{imm[15]}}, imm};
    endcase
end

assign rs_addr = use_rs ? rs : '0;
assign rt_addr = use_rt ? rt : '0;
assign dest    = !dec_ok ? '0 : ((opcode == OP_RTYPE) ? rd : rt);

//////////////////////////////////////////////////////////////////////
//  ID/EX register
//////////////////////////////////////////////////////////////////////

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        ex_valid     <= 1'b0;
        ex_reg_w     <= 1'b0;
        ex_alu_op    <= ALU_ADD;
        ex_shift_op  <= SH_LL;
        ex_res_sel   <= RES_ALU;
        ex_b_imm     <= 1'b0;
        ex_shamt_var <= 1'b0;
        ex_rs_addr   <= '0;
        ex_rt_addr   <= '0;
        ex_rd_addr   <= '0;
    end else begin
        ex_valid     <= if_valid;
        ex_reg_w     <= if_valid & dec_ok;
        ex_alu_op    <= alu_op;
        ex_shift_op  <= shift_op;
        ex_res_sel   <= res_sel;
        ex_b_imm     <= b_imm;
        ex_shamt_var <= shamt_var;
        ex_rs_addr   <= rs_addr;
        ex_rt_addr   <= rt_addr;
        ex_rd_addr   <= dest;
    end
end

always_ff @(posedge clk) begin
    ex_shamt <= shamt;
    ex_imm   <= imm_word;
    ex_op_a  <= rs_data;
    ex_op_b  <= rt_data;
end

endmodule

`default_nettype wire

//--- hdl/instr_queue.sv
`timescale 1ns/10ps
`default_nettype none

module instr_queue (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  cpu_pkg::instr_t instr,
    output logic            if_valid,
    output cpu_pkg::instr_t if_instr,
    output logic            credit
);

import cpu_pkg::*;

instr_t                         slots [QUEUE_DEPTH];
logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
logic [CREDIT_W-1:0]            count;
logic                           pop;

// Head leaves every cycle the buffer holds something
assign pop    = (count != '0);
assign credit = pop;

// Pointers wrap on their own, depth is a power of two
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr   <= '0;
        rd_ptr   <= '0;
        count    <= '0;
        if_valid <= 1'b0;
    end else begin
        if (instr_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        count    <= count + CREDIT_W'(instr_valid) - CREDIT_W'(pop);
        if_valid <= pop;
    end
end

always_ff @(posedge clk) begin
    if (instr_valid) begin
        slots[wr_ptr] <= instr;
    end
    if (pop) begin
        if_instr <= slots[rd_ptr];
    end
end

endmodule

`default_nettype wire

//--- hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

//////////////////////////////////////////////////////////////////////
//  Vector types
//////////////////////////////////////////////////////////////////////

typedef logic [31:0] word_t;
typedef logic [31:0] instr_t;
typedef logic [4:0]  reg_addr_t;
typedef logic [4:0]  shamt_t;
typedef logic [15:0] imm_t;
typedef logic [5:0]  opcode_t;
typedef logic [5:0]  funct_t;

//////////////////////////////////////////////////////////////////////
//  Control encodings
//////////////////////////////////////////////////////////////////////

typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLT,
    ALU_SLTU
} alu_op_t;

typedef enum logic [1:0] {SH_LL, SH_RL, SH_RA} shift_op_t;

// EXT_UPPER places the immediate in the high half (lui)
typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} imm_ext_t;

typedef enum logic {RES_ALU, RES_SHIFT} res_sel_t;

typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

//////////////////////////////////////////////////////////////////////
//  Opcode and funct fields
//////////////////////////////////////////////////////////////////////

localparam opcode_t OP_RTYPE = 6'h00;
localparam opcode_t OP_ADDIU = 6'h09;
localparam opcode_t OP_SLTI  = 6'h0a;
localparam opcode_t OP_SLTIU = 6'h0b;
localparam opcode_t OP_ANDI  = 6'h0c;
localparam opcode_t OP_ORI   = 6'h0d;
localparam opcode_t OP_XORI  = 6'h0e;
localparam opcode_t OP_LUI   = 6'h0f;

// Shift functs: bit 2 picks the variable amount, bits 1:0 the kind
localparam funct_t FN_SLL  = 6'h00;
localparam funct_t FN_SRL  = 6'h02;
localparam funct_t FN_SRA  = 6'h03;
localparam funct_t FN_SLLV = 6'h04;
localparam funct_t FN_SRLV = 6'h06;
localparam funct_t FN_SRAV = 6'h07;
localparam funct_t FN_ADDU = 6'h21;
localparam funct_t FN_SUBU = 6'h23;
localparam funct_t FN_AND  = 6'h24;
localparam funct_t FN_OR   = 6'h25;
localparam funct_t FN_XOR  = 6'h26;
localparam funct_t FN_NOR  = 6'h27;
localparam funct_t FN_SLT  = 6'h2a;
localparam funct_t FN_SLTU = 6'h2b;

// Queue size, also the credits a sender starts with
localparam int QUEUE_DEPTH = 4;
localparam int CREDIT_W    = 3;

endpackage

`default_nettype wire
